// ==== sim.f ====
+incdir+rtl
rtl/ql_pkg.sv
rtl/ql_bus_port.sv
rtl/ql_timer_irq.sv
rtl/ql_ipc.sv
rtl/ql_read_return.sv
rtl/ql_periph_top.sv
sim/ql_props.sv
sim/ql_tb.sv

// ==== Bender.yml ====
package:
  name: ql_periph

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ql_pkg.sv
      - rtl/ql_bus_port.sv
      - rtl/ql_timer_irq.sv
      - rtl/ql_ipc.sv
      - rtl/ql_read_return.sv
      - rtl/ql_periph_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/ql_props.sv
      - sim/ql_tb.sv

// ==== sim/ql_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ql_consts.svh"

module ql_tb;

  import ql_pkg::*;

  logic        clk_cpu;
  logic        reset;
  logic        i_req;
  ql_bus_req_t i_bus;
  logic        o_ack;
  logic [15:0] o_rdata;
  logic        i_vsync;        // Active low
  logic [63:0] i_kbd_matrix;
  logic        i_key_event;
  logic        o_mode;

  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          tests;
  int          tests_failed;
  int          test_err0;      // Error count at test start

  ql_periph_top #(.P_TICK_DIV(8)) dut (
    .clk_cpu, .reset, .i_req, .i_bus, .o_ack, .o_rdata,
    .i_vsync, .i_kbd_matrix, .i_key_event, .o_mode
  );

  // 25 MHz CPU clock
  initial begin
    clk_cpu = 1'b0;
    forever #20 clk_cpu = ~clk_cpu;
  end

  // ========================================
  // Random bits
  // ========================================
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v    = {v[62:0], lfsr[0]};   // One step per bit
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // Expected IPC answer, right-aligned to its bit count
  function automatic logic [15:0] ref_ipc(input logic [3:0] cmd, input logic [63:0] m,
                                          input logic kp, input logic [3:0] param);
    logic [2:0] row;
    logic [2:0] col;
    logic       found;
    int         r;
    row   = 3'd7;
    col   = 3'd7;
    found = 1'b0;
    for (r = 0; r < 8; r++) begin
      if (!found && m[8*r +: 8] != 8'd0) begin  // First busy row
        row   = r[2:0];
        found = 1'b1;
      end
    end
    found = 1'b0;
    for (r = 0; r < 8; r++) begin
      if (!found && m[8*row + r]) begin         // Lowest column
        col   = r[2:0];
        found = 1'b1;
      end
    end
    case (cmd)
      `QL_CMD_STATUS:  return {15'd0, kp};
      `QL_CMD_READKEY: return {4'b0001, 1'b0, m[56], m[57], m[58], 2'b00, row, col};
      `QL_CMD_KEYROW:  return {8'd0, m[8*param[2:0] +: 8]};
      default:         return 16'd0;
    endcase
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors != test_err0) tests_failed++;
    $display("%-10s %s (%0d errors)", name, (errors == test_err0) ? "passed" : "failed",
             errors - test_err0);
    test_err0 = errors;
  endtask

  // ========================================
  // Four-phase bus access
  // ========================================
  task automatic bus_access(input logic we, input logic uds, input logic lds,
                            input logic [8:0] word_addr, input logic [15:0] wdata,
                            input int hold, output logic [15:0] rdata);
    int n;
    rdata = '0;
    @(negedge clk_cpu);
    i_bus.addr  = word_addr;
    i_bus.we    = we;
    i_bus.uds   = uds;
    i_bus.lds   = lds;
    i_bus.wdata = wdata;
    i_req       = 1'b1;
    n = 0;
    while (!o_ack && n < 16) begin
      @(negedge clk_cpu);
      n++;
    end
    if (!o_ack) begin
      $display("Timeout at %0t ns: no ack for the access at word address 0x%0h",
               $time, word_addr);
      errors++;
    end else begin
      check("ack latency", n, 3);   // Strobe, done, ack
      rdata = o_rdata;
      repeat (hold) begin           // Master stalls with req high
        @(negedge clk_cpu);
        check("o_ack", o_ack, 1'b1);
        check("o_rdata", o_rdata, rdata);
      end
    end
    i_req = 1'b0;
    n = 0;
    while (o_ack && n < 8) begin
      @(negedge clk_cpu);
      n++;
    end
    if (o_ack) begin
      $display("Timeout at %0t ns: ack stayed high after the request dropped", $time);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [8:0] word_addr, input logic uds, input logic lds,
                           input logic [15:0] wdata);
    logic [15:0] unused;
    bus_access(1'b1, uds, lds, word_addr, wdata, 0, unused);
  endtask

  task automatic bus_read(input logic [8:0] word_addr, output logic [15:0] rdata);
    bus_access(1'b0, 1'b1, 1'b1, word_addr, 16'd0, 0, rdata);
  endtask

  // One IPC bit, data bit 0 clear
  task automatic send_ipc_bit(input logic b);
    bus_write({3'd0, `QL_OFS_IPCWR}, 1'b0, 1'b1, {14'd0, b, 1'b0});
  endtask

  // Command, optional parameter, then nbits answer bits via the status bit
  task automatic run_ipc(input logic [3:0] cmd, input logic [3:0] param, input int nbits,
                         output logic [15:0] result);
    logic [15:0] rd;
    int          i;
    result = '0;
    for (i = 3; i >= 0; i--) send_ipc_bit(cmd[i]);       // MSB first
    if (cmd == `QL_CMD_KEYROW) begin
      for (i = 3; i >= 0; i--) send_ipc_bit(param[i]);
    end
    for (i = 0; i < nbits; i++) begin
      send_ipc_bit(1'b1);
      bus_read({3'd0, `QL_OFS_IRQ}, rd);
      result = {result[14:0], rd[15]};
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    logic [15:0] rd;
    logic [15:0] hi;
    logic [15:0] lo;
    logic [15:0] res;
    logic [63:0] val;
    logic [63:0] got;
    logic [63:0] m;
    logic [3:0]  param;
    time         t0;
    longint      elapsed;
    int          i;
    reset        = 1'b1;
    i_req        = 1'b0;
    i_bus        = '0;
    i_vsync      = 1'b1;
    i_kbd_matrix = '0;
    i_key_event  = 1'b0;
    lfsr         = 32'd55;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    tests_failed = 0;
    test_err0    = 0;
    repeat (3) @(posedge clk_cpu);   // Three reset cycles
    @(negedge clk_cpu);
    reset = 1'b0;

    // Handshake, back-pressure, display mode
    check("o_ack", o_ack, 1'b0);
    check("o_mode", o_mode, 1'b1);
    bus_access(1'b0, 1'b1, 1'b1, {3'd0, `QL_OFS_DISPLAY}, 16'd0, 3, rd);
    check("o_rdata", rd, 16'd0);          // Write-only port
    bus_write({3'd0, `QL_OFS_DISPLAY}, 1'b0, 1'b1, 16'h0000);
    check("o_mode", o_mode, 1'b0);
    bus_write({3'd0, `QL_OFS_DISPLAY}, 1'b0, 1'b1, 16'h0008);
    check("o_mode", o_mode, 1'b1);
    finish_test("handshake");

    // Timer reset then byte adjust from the top
    bus_write({3'd0, `QL_OFS_TIMER}, 1'b1, 1'b0, 16'd0);
    val = rand_bits(32);
    for (i = 3; i >= 0; i--) begin
      if (i == 0) t0 = $time;
      bus_write({3'd0, `QL_OFS_TIMER}, 1'b0, 1'b1, {8'd0, val[8*i +: 8]});
    end
    bus_read({3'd0, `QL_OFS_TIMER}, hi);
    bus_read({3'd0, (`QL_OFS_TIMER + 6'd1)}, lo);    // Low half at a[1] set
    elapsed = ($time - t0) / 40;
    got     = {32'd0, hi, lo};
    check("timer lower bound", got >= val, 1'b1);
    check("timer upper bound", got <= val + elapsed / 8 + 1, 1'b1);
    finish_test("timer");

    // Frame interrupt and its ack
    bus_read({3'd0, `QL_OFS_IRQ}, rd);
    check("pending[3]", rd[3], 1'b0);
    @(negedge clk_cpu);
    i_vsync = 1'b0;
    @(negedge clk_cpu);
    i_vsync = 1'b1;
    bus_read({3'd0, `QL_OFS_IRQ}, rd);
    check("pending[3]", rd[3], 1'b1);
    bus_write({3'd0, `QL_OFS_IRQ}, 1'b0, 1'b1, 16'h0008);
    bus_read({3'd0, `QL_OFS_IRQ}, rd);
    check("pending[3]", rd[3], 1'b0);
    finish_test("vsync");

    // IPC status, key flag clears on read
    @(negedge clk_cpu);
    i_key_event = 1'b1;
    @(negedge clk_cpu);
    i_key_event = 1'b0;
    run_ipc(`QL_CMD_STATUS, 4'd0, 8, res);
    check("ipc status", res, ref_ipc(`QL_CMD_STATUS, i_kbd_matrix, 1'b1, 4'd0));
    run_ipc(`QL_CMD_STATUS, 4'd0, 8, res);
    check("ipc status", res, ref_ipc(`QL_CMD_STATUS, i_kbd_matrix, 1'b0, 4'd0));
    finish_test("ipc_status");

    // Read key on sparse matrices, first one empty
    for (i = 0; i < 5; i++) begin
      m = (i == 0) ? 64'd0 : (rand_bits(64) & rand_bits(64) & rand_bits(64));
      @(negedge clk_cpu);
      i_kbd_matrix = m;
      run_ipc(`QL_CMD_READKEY, 4'd0, 16, res);
      check("ipc read key", res, ref_ipc(`QL_CMD_READKEY, m, 1'b0, 4'd0));
    end
    // Key row and the direct row read
    for (i = 0; i < 2; i++) begin
      m     = rand_bits(64);
      param = 4'(rand_bits(4));
      @(negedge clk_cpu);
      i_kbd_matrix = m;
      run_ipc(`QL_CMD_KEYROW, param, 8, res);
      check("ipc key row", res, ref_ipc(`QL_CMD_KEYROW, m, 1'b0, param));
      bus_read({param[2:0], `QL_OFS_KEYBD}, rd);
      check("keyboard row", rd, ref_ipc(`QL_CMD_KEYROW, m, 1'b0, param));
    end
    finish_test("ipc_keys");

    // Bound handshake checker
    if (dut.u_bus_port.u_props.n_fail != 0) begin
      $display("Handshake assertions failed %0d times", dut.u_bus_port.u_props.n_fail);
      errors += dut.u_bus_port.u_props.n_fail;
    end

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/ql_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module ql_props (
  input wire                      clk_cpu,
  input wire                      reset,
  input wire                      i_req,
  input wire ql_pkg::ql_bus_req_t i_bus,
  input wire                      i_ack    // Bus port o_ack
);

  int n_fail = 0;   // Failed assertion count

  // ========================================
  // Four-phase handshake
  // ========================================
  a_ack_needs_req: assert property (@(posedge clk_cpu) disable iff (reset)
    $rose(i_ack) |-> $past(i_req))
    else begin
      $error("ack rose with no request behind it");
      n_fail++;
    end

  // Master keeps the payload until req drops
  a_bus_stable: assert property (@(posedge clk_cpu) disable iff (reset)
    (i_req && i_ack) |=> (!i_req || $stable(i_bus)))
    else begin
      $error("bus payload changed while acked");
      n_fail++;
    end

  a_ack_falls: assert property (@(posedge clk_cpu) disable iff (reset)
    $fell(i_req) |-> ##[0:2] !i_ack)
    else begin
      $error("ack still high two cycles after req fell");
      n_fail++;
    end

endmodule

bind ql_bus_port ql_props u_props (
  .clk_cpu (clk_cpu),
  .reset   (reset),
  .i_req   (i_req),
  .i_bus   (i_bus),
  .i_ack   (o_ack)
);

`default_nettype wire

// ==== rtl/ql_periph_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ql_consts.svh"

module ql_periph_top #(
  parameter int P_TICK_DIV = `QL_TICK_DIV_DEFAULT
) (
  input  wire                      clk_cpu,
  input  wire                      reset,
  input  wire                      i_req,
  input  wire ql_pkg::ql_bus_req_t i_bus,
  output logic                     o_ack,
  output logic [`QL_DATA_W-1:0]    o_rdata,
  input  wire                      i_vsync,
  input  wire [`QL_KBD_W-1:0]      i_kbd_matrix,
  input  wire                      i_key_event,
  output logic                     o_mode
);

  import ql_pkg::*;

  logic                  stb;
  ql_bus_req_t           req_q;     // Captured access
  ql_port_sel_t          sel;
  logic                  done;
  logic [`QL_TIMER_W-1:0] timer;
  logic [`QL_PEND_W-1:0]  pending;
  logic                  status_bit;

  // ========================================
  // Input side
  // ========================================
  ql_bus_port u_bus_port (
    .clk_cpu, .reset, .i_req, .i_bus,
    .i_done (done),
    .o_ack,
    .o_stb  (stb),
    .o_req  (req_q),
    .o_sel  (sel)
  );

  ql_timer_irq #(.P_TICK_DIV(P_TICK_DIV)) u_timer_irq (
    .clk_cpu, .reset, .i_stb(stb), .i_req(req_q), .i_sel(sel), .i_vsync,
    .o_timer(timer), .o_pending(pending), .o_mode
  );

  ql_ipc u_ipc (
    .clk_cpu, .reset, .i_stb(stb), .i_req(req_q), .i_sel(sel),
    .i_kbd_matrix, .i_key_event, .o_status_bit(status_bit)
  );

  // Output side
  ql_read_return u_read_return (
    .clk_cpu, .reset, .i_stb(stb), .i_req(req_q), .i_sel(sel),
    .i_timer(timer), .i_pending(pending), .i_status_bit(status_bit),
    .i_kbd_matrix, .o_done(done), .o_rdata
  );

endmodule

`default_nettype wire

// ==== rtl/ql_read_return.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ql_consts.svh"

module ql_read_return (
  input  wire                       clk_cpu,
  input  wire                       reset,
  input  wire                       i_stb,
  input  wire ql_pkg::ql_bus_req_t  i_req,
  input  wire ql_pkg::ql_port_sel_t i_sel,
  input  wire [`QL_TIMER_W-1:0]     i_timer,
  input  wire [`QL_PEND_W-1:0]      i_pending,
  input  wire                       i_status_bit,  // IPC return MSB
  input  wire [`QL_KBD_W-1:0]       i_kbd_matrix,
  output logic                      o_done,
  output logic [`QL_DATA_W-1:0]     o_rdata
);

  logic [`QL_DATA_W-1:0] rd_word;

  // Read multiplexer
  always_comb begin
    rd_word = '0;                                  // Unmapped reads as zero
    if (i_sel.timer)
      rd_word = i_sel.timer_half ? i_timer[15:0] : i_timer[31:16];
    else if (i_sel.keybd)
      rd_word = {8'h00, i_kbd_matrix[{i_req.addr[8:6], 3'b000} +: 8]};  // a[9:7]
    else if (i_sel.irq)
      rd_word = {i_status_bit, 7'b0, i_pending};
  end

  always_ff @(posedge clk_cpu) begin
    if (i_stb) o_rdata <= rd_word;   // Held until next access
  end

  always_ff @(posedge clk_cpu) begin
    if (reset) o_done <= 1'b0;
    else       o_done <= i_stb;
  end

endmodule

`default_nettype wire

// ==== rtl/ql_ipc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ql_consts.svh"

module ql_ipc (
  input  wire                       clk_cpu,
  input  wire                       reset,
  input  wire                       i_stb,
  input  wire ql_pkg::ql_bus_req_t  i_req,
  input  wire ql_pkg::ql_port_sel_t i_sel,
  input  wire [`QL_KBD_W-1:0]       i_kbd_matrix,
  input  wire                       i_key_event,   // New key press
  output logic                      o_status_bit
);

  import ql_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,    // Collecting command bits
    ST_SEND,    // Shifting return word out
    ST_PARAM    // Collecting parameter bits
  } state_t;

  state_t      state;
  logic [2:0]  ipc_data;     // Last three bits received
  logic [3:0]  ipc_shift;
  logic [3:0]  bit_cnt;
  logic [3:0]  bit_last;     // Bit count minus one
  logic [15:0] ipc_ret;      // Return word, MSB goes first
  logic        key_pressed;
  logic        bit_wr;
  ql_key_t     key;
  logic [7:0]  row_bits;

  // Writes with data bit 0 set carry no bit
  assign bit_wr    = i_stb && i_req.we && i_sel.ipcwr && i_req.lds && !i_req.wdata[0];
  assign ipc_shift = {ipc_data, i_req.wdata[1]};

  // ========================================
  // Key encoder
  // ========================================
  always_comb begin
    key       = '0;
    key.shift = i_kbd_matrix[56];
    key.ctrl  = i_kbd_matrix[57];
    key.alt   = i_kbd_matrix[58];
    key.row   = 3'd7;                           // No key anywhere
    for (int r = 6; r >= 0; r--) begin
      if (|i_kbd_matrix[8*r +: 8]) key.row = r[2:0];  // First row wins
    end
    row_bits = i_kbd_matrix[{key.row, 3'b000} +: 8];
    key.col  = 3'd7;
    for (int c = 6; c >= 0; c--) begin
      if (row_bits[c]) key.col = c[2:0];       // Lowest column wins
    end
  end

  // ========================================
  // Command engine
  // ========================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      state       <= ST_IDLE;
      bit_cnt     <= '0;
      ipc_data    <= '0;
      ipc_ret     <= '0;
      key_pressed <= 1'b0;
    end else begin
      if (i_key_event) key_pressed <= 1'b1;
      if (bit_wr) begin
        ipc_data <= ipc_shift[2:0];
        bit_cnt  <= bit_cnt + 1'b1;
        case (state)
          ST_IDLE: if (bit_cnt[1:0] == 2'd3) begin   // Fourth bit
            bit_cnt <= '0;
            case (ipc_shift)
              `QL_CMD_STATUS: begin
                state       <= ST_SEND;
                bit_last    <= 4'd7;
                ipc_ret     <= {7'b0, key_pressed, 8'b0};
                key_pressed <= 1'b0;
              end
              `QL_CMD_READKEY: begin
                state    <= ST_SEND;
                bit_last <= 4'd15;
                ipc_ret  <= {4'b0001, 1'b0, key.shift, key.ctrl, key.alt,
                             2'b00, key.row, key.col};
              end
              `QL_CMD_KEYROW: begin
                state    <= ST_PARAM;
                bit_last <= 4'd3;     // Row number
              end
              default: ;              // Unsupported, ignored
            endcase
          end
          ST_SEND: begin
            if (bit_cnt != 0) ipc_ret <= {ipc_ret[14:0], 1'b0};  // First bit in place
            if (bit_cnt == bit_last) begin
              state   <= ST_IDLE;
              bit_cnt <= '0;
            end
          end
          ST_PARAM: if (bit_cnt == bit_last) begin
            state    <= ST_SEND;
            bit_cnt  <= '0;
            bit_last <= 4'd7;
            ipc_ret  <= {i_kbd_matrix[{ipc_shift[2:0], 3'b000} +: 8], 8'b0};
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  assign o_status_bit = ipc_ret[15];

endmodule

`default_nettype wire

// ==== rtl/ql_timer_irq.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ql_consts.svh"

module ql_timer_irq #(
  parameter int P_TICK_DIV = `QL_TICK_DIV_DEFAULT  // Cycles per second
) (
  input  wire                       clk_cpu,
  input  wire                       reset,
  input  wire                       i_stb,
  input  wire ql_pkg::ql_bus_req_t  i_req,
  input  wire ql_pkg::ql_port_sel_t i_sel,
  input  wire                       i_vsync,    // Active low
  output logic [`QL_TIMER_W-1:0]    o_timer,
  output logic [`QL_PEND_W-1:0]     o_pending,
  output logic                      o_mode
);

  localparam int P_PRE_W = $clog2(P_TICK_DIV);

  logic [P_PRE_W-1:0] prescaler;
  logic [1:0]         timer_byte;   // Next byte to adjust, 0 = top
  logic               vsync_q;
  logic               vsync_flag;
  logic [7:0]         irq_ctl;      // {mask[2:0], ack[4:0]}
  logic               wr;
  logic               tmr_wr;

  assign wr     = i_stb && i_req.we;
  assign tmr_wr = wr && i_sel.timer && !i_sel.timer_half;  // $18000/01 only

  // ========================================
  // Seconds timer
  // ========================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      prescaler  <= '0;
      o_timer    <= '0;
      timer_byte <= '0;
    end else begin
      if (prescaler == P_PRE_W'(P_TICK_DIV - 1)) begin
        prescaler <= '0;
        o_timer   <= o_timer + 1'b1;
      end else begin
        prescaler <= prescaler + 1'b1;
      end
      if (tmr_wr && i_req.uds) begin      // Reset write
        o_timer    <= '0;
        timer_byte <= '0;
      end else if (tmr_wr && i_req.lds) begin  // Adjust, MSB first
        o_timer[{~timer_byte, 3'b000} +: 8] <= i_req.wdata[7:0];
        timer_byte <= timer_byte + 1'b1;
      end
    end
  end

  // ========================================
  // Interrupt register and display mode
  // ========================================
  always_ff @(posedge clk_cpu) begin
    vsync_q <= i_vsync;
    if (reset) begin
      vsync_flag <= 1'b0;
      irq_ctl    <= '0;
      o_mode     <= 1'b1;               // 256x256 after reset
    end else begin
      irq_ctl[4:0] <= '0;              // Ack bits only live one cycle
      if (wr && i_sel.irq && i_req.lds) irq_ctl <= i_req.wdata[7:0];
      if (wr && i_sel.display) o_mode <= i_req.wdata[3];
      if (irq_ctl[3]) vsync_flag <= 1'b0;       // Frame ack
      else if (vsync_q && !i_vsync) vsync_flag <= 1'b1;  // Falling edge
    end
  end

  // Timer tick at bit 5, frame at bit 3
  assign o_pending = {2'b00, o_timer[0], 1'b0, vsync_flag, 3'b000};

endmodule

`default_nettype wire

// ==== rtl/ql_bus_port.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ql_consts.svh"

module ql_bus_port (
  input  wire                  clk_cpu,
  input  wire                  reset,
  input  wire                  i_req,     // Four-phase request
  input  wire ql_pkg::ql_bus_req_t  i_bus,
  input  wire                  i_done,    // From read return
  output logic                 o_ack,
  output logic                 o_stb,     // One cycle per access
  output ql_pkg::ql_bus_req_t  o_req,
  output ql_pkg::ql_port_sel_t o_sel
);

  import ql_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUSY,   // Strobe issued, waiting for done
    ST_ACKED   // Ack high until req drops
  } state_t;

  state_t state;

  // ========================================
  // Offset decode
  // ========================================
  function automatic ql_port_sel_t decode(input logic [`QL_ADDR_W-1:0] addr);
    ql_port_sel_t sel;
    sel.timer      = (addr[5:0] & 6'b111110) == `QL_OFS_TIMER; // Two words
    sel.ipcwr      = addr[5:0] == `QL_OFS_IPCWR;
    sel.irq        = addr[5:0] == `QL_OFS_IRQ;
    sel.keybd      = addr[5:0] == `QL_OFS_KEYBD;  // a[9:7] ignored here
    sel.display    = addr[5:0] == `QL_OFS_DISPLAY;
    sel.timer_half = addr[0];
    return sel;
  endfunction

  // Payload capture, no reset
  always_ff @(posedge clk_cpu) begin
    if (state == ST_IDLE && i_req) begin
      o_req <= i_bus;
      o_sel <= decode(i_bus.addr);
    end
  end

  // ========================================
  // Handshake FSM
  // ========================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      state <= ST_IDLE;
      o_stb <= 1'b0;
      o_ack <= 1'b0;
    end else begin
      o_stb <= 1'b0;                   // Pulse by default
      case (state)
        ST_IDLE: if (i_req) begin
          o_stb <= 1'b1;
          state <= ST_BUSY;
        end
        ST_BUSY: if (i_done) begin
          o_ack <= 1'b1;                 // Read data already registered
          state <= ST_ACKED;
        end
        ST_ACKED: if (!i_req) begin     // Held high stalls here
          o_ack <= 1'b0;
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ql_pkg.sv ====
`default_nettype none

package ql_pkg;

  `include "ql_consts.svh"

  // One captured CPU access
  typedef struct packed {
    logic [`QL_ADDR_W-1:0] addr;   // a[9:1]
    logic                  we;     // 1 = write
    logic                  uds;    // Upper byte strobe
    logic                  lds;    // Lower byte strobe
    logic [`QL_DATA_W-1:0] wdata;
  } ql_bus_req_t;

  // Decoded port selects
  typedef struct packed {
    logic timer;       // Offsets 0 and 1
    logic ipcwr;
    logic irq;
    logic keybd;
    logic display;
    logic timer_half;  // a[1], set for the low half
  } ql_port_sel_t;

  // Encoded key for the read key command
  typedef struct packed {
    logic       shift;
    logic       ctrl;
    logic       alt;
    logic [2:0] row;
    logic [2:0] col;
  } ql_key_t;

endpackage

`default_nettype wire

// ==== rtl/ql_consts.svh ====
`ifndef QL_CONSTS_SVH
`define QL_CONSTS_SVH

// ========================================
// Bus and data widths
// ========================================
`define QL_ADDR_W   9            // Word address a[9:1]
`define QL_DATA_W   16           // CPU data bus
`define QL_TIMER_W  32           // Seconds counter
`define QL_PEND_W   8            // Interrupt pending byte
`define QL_KBD_W    64           // 8 rows x 8 columns

// Peripheral word offsets, a[6:1] from $18000
`define QL_OFS_TIMER    6'd0     // $18000..$18003, both halves
`define QL_OFS_IPCWR    6'd1     // $18003
`define QL_OFS_KEYBD    6'd5     // $1800B, row from a[9:7]
`define QL_OFS_IRQ      6'd16    // $18020/21
`define QL_OFS_DISPLAY  6'd49    // $18063

// IPC commands
`define QL_CMD_STATUS   4'd1
`define QL_CMD_READKEY  4'd8
`define QL_CMD_KEYROW   4'd9

`define QL_TICK_DIV_DEFAULT 27000000  // CPU clock cycles per second

`endif
